//--- lsu_subsys.f
+incdir+common
common/lsu_pkg.sv
lsu/lsu_core.sv
logic/bank_router.sv
logic/mem_bank.sv
logic/resp_merge.sv
logic/lsu_subsys.sv
dv/clk_gen.sv
dv/lsu_subsys_checker.sv
dv/lsu_subsys_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f lsu_subsys.f --top-module lsu_subsys_tb -Mdir obj_dir

# a higher error limit lets the testbench report the first failed assertion itself
./obj_dir/Vlsu_subsys_tb +verilator+error+limit+100

//--- dv/lsu_subsys_tb.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_subsys_tb;

  localparam int WORDS   = `LSU_N_BANKS * `LSU_BANK_WORDS;
  localparam int TIMEOUT = 200;
  localparam logic [`LSU_ADDR_W-1:0] LIMIT = WORDS * 4;

  logic                   clk;
  logic                   rst_i;
  logic                   req_i;
  lsu_pkg::mem_op_e       op_i;
  logic [`LSU_ADDR_W-1:0] addr_i;
  logic [`LSU_DATA_W-1:0] wdata_i;
  logic [`LSU_DATA_W-1:0] rdata_o;
  logic                   rvalid_o;
  logic                   wready_o;
  logic                   err_o;

  clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst_i));

  lsu_subsys lsu_subsys_i (
    .clk, .rst_i, .req_i, .op_i, .addr_i, .wdata_i,
    .rdata_o, .rvalid_o, .wready_o, .err_o
  );

  bind lsu_subsys lsu_subsys_checker lsu_subsys_checker_i (
    .clk(clk), .rst_i(rst_i), .req_i(req_i), .op_i(op_i), .addr_i(addr_i),
    .wdata_i(wdata_i), .rdata_i(rdata_o), .rvalid_i(rvalid_o), .wready_i(wready_o),
    .err_i(err_o)
  );

  task automatic set_test(input string name);
    lsu_subsys_i.lsu_subsys_checker_i.test_name = name;
  endtask

  // one request, held until its completion pulse has gone by
  task automatic access(input lsu_pkg::mem_op_e op, input logic [`LSU_ADDR_W-1:0] addr,
                        input logic [`LSU_DATA_W-1:0] data);
    int waited;
    waited  = 0;
    req_i   = 1'b1;
    op_i    = op;
    addr_i  = addr;
    wdata_i = data;
    @(negedge clk);
    while (!(rvalid_o || wready_o)) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("tests failed");
        $fatal(1, "timeout: no completion for %s at address %h", op.name(), addr);
      end
      @(negedge clk);
    end
    @(negedge clk);
    req_i = 1'b0;
    op_i  = lsu_pkg::NONE;
  endtask

  function automatic logic [`LSU_DATA_W-1:0] fill_word(input logic [`LSU_ADDR_W-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  // in range address, aligned to the access size
  function automatic logic [`LSU_ADDR_W-1:0] rand_addr(input lsu_pkg::mem_op_e op);
    logic [`LSU_ADDR_W-1:0] a;
    a = $urandom % LIMIT;
    if (op inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) a[0] = 1'b0;
    if (op inside {lsu_pkg::LW, lsu_pkg::SW}) a[1:0] = 2'b00;
    return a;
  endfunction

  always @(negedge clk) begin
    if (lsu_subsys_i.lsu_subsys_checker_i.fail_cnt != 0) begin
      $display("tests failed");
      $fatal(1, "checker assertion failed");
    end
  end

  initial begin
    int                     waited;
    logic [`LSU_ADDR_W-1:0] a;
    lsu_pkg::mem_op_e       op;
    req_i   = 1'b0;
    op_i    = lsu_pkg::NONE;
    addr_i  = '0;
    wdata_i = '0;
    void'($urandom(57892));
    set_test("reset");
    waited = 0;
    @(negedge clk);
    while (rst_i) begin
      waited++;
      if (waited > 50) begin
        $display("tests failed");
        $fatal(1, "timeout: reset never released");
      end
      @(negedge clk);
    end
    repeat (3) @(negedge clk);

    // every word gets a known value first
    set_test("fill");
    for (int w = 0; w < WORDS; w++) access(lsu_pkg::SW, 32'(w * 4), fill_word(32'(w * 4)));

    set_test("word_rw");
    repeat (8) begin
      a = rand_addr(lsu_pkg::SW);
      access(lsu_pkg::SW, a, $urandom);
      access(lsu_pkg::LW, a, '0);
    end

    set_test("sign_ext");
    for (int p = 0; p < 2; p++) begin
      a = rand_addr(lsu_pkg::SW);
      access(lsu_pkg::SW, a, (p == 0) ? 32'hf2a3_9485 : 32'h7f31_6205);
      for (int off = 0; off < 4; off++) begin
        access(lsu_pkg::LB, a + 32'(off), '0);
        access(lsu_pkg::LBU, a + 32'(off), '0);
        if (off % 2 == 0) begin
          access(lsu_pkg::LH, a + 32'(off), '0);
          access(lsu_pkg::LHU, a + 32'(off), '0);
        end
      end
    end

    set_test("sub_word");
    a = rand_addr(lsu_pkg::SW);
    for (int off = 0; off < 4; off++) begin
      access(lsu_pkg::SW, a, $urandom);
      access(lsu_pkg::SB, a + 32'(off), $urandom);
      access(lsu_pkg::LW, a, '0);
      if (off % 2 == 0) begin
        access(lsu_pkg::SH, a + 32'(off), $urandom);
        access(lsu_pkg::LW, a, '0);
      end
    end

    // aliased in-range word must be left alone
    set_test("decode_err");
    a = rand_addr(lsu_pkg::SW);
    access(lsu_pkg::SW, a + LIMIT, $urandom);
    access(lsu_pkg::LW, a + LIMIT, '0);
    access(lsu_pkg::LB, 32'hffff_fffd, '0);
    access(lsu_pkg::SH, 32'h8000_0002, $urandom);
    access(lsu_pkg::LW, a, '0);

    set_test("random");
    repeat (300) begin
      op = lsu_pkg::mem_op_e'(4'($urandom % 8) + 4'd1);
      a  = rand_addr(op);
      if ($urandom % 16 == 0) a = a + LIMIT;
      access(op, a, $urandom);
    end

    @(negedge clk);
    if (lsu_subsys_i.lsu_subsys_checker_i.fail_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "checker assertions failed");
    end
  end

endmodule

//--- dv/lsu_subsys_checker.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_subsys_checker (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  lsu_pkg::mem_op_e         op_i,
  input  logic [`LSU_ADDR_W-1:0]   addr_i,
  input  logic [`LSU_DATA_W-1:0]   wdata_i,
  input  logic [`LSU_DATA_W-1:0]   rdata_i,
  input  logic                     rvalid_i,
  input  logic                     wready_i,
  input  logic                     err_i
);

  localparam int BYTES = `LSU_N_BANKS * `LSU_BANK_WORDS * 4;
  localparam int IDX_W = $clog2(BYTES);
  localparam logic [`LSU_ADDR_W-1:0] LIMIT = BYTES;

  string                  test_name;
  int                     fail_cnt = 0;
  logic [7:0]             shadow [BYTES];
  logic [IDX_W-1:0]       base;
  logic [`LSU_DATA_W-1:0] exp_rdata;
  logic                   exp_err;
  logic                   is_ld;
  logic                   is_st;
  logic                   done;
  logic                   pend_q;
  logic                   rst_q;
  logic                   seen_rst_q = 1'b0;

  assign base    = addr_i[IDX_W-1:0];
  assign exp_err = addr_i >= LIMIT;
  assign is_ld   = op_i inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::LW};
  assign is_st   = op_i inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
  assign done    = rvalid_i | wready_i;

  // load result from the byte copy, little endian
  always_comb begin
    case (op_i)
      lsu_pkg::LB:  exp_rdata = {{(`LSU_DATA_W-8){shadow[base][7]}}, shadow[base]};
      lsu_pkg::LBU: exp_rdata = {{(`LSU_DATA_W-8){1'b0}}, shadow[base]};
      lsu_pkg::LH:  exp_rdata = {{(`LSU_DATA_W-16){shadow[base + IDX_W'(1)][7]}},
                                 shadow[base + IDX_W'(1)], shadow[base]};
      lsu_pkg::LHU: exp_rdata = {{(`LSU_DATA_W-16){1'b0}}, shadow[base + IDX_W'(1)], shadow[base]};
      lsu_pkg::LW:  exp_rdata = {shadow[base + IDX_W'(3)], shadow[base + IDX_W'(2)],
                                 shadow[base + IDX_W'(1)], shadow[base]};
      default:      exp_rdata = '0;
    endcase
    if (exp_err) exp_rdata = '0;
  end

  always @(posedge clk) begin
    if (!rst_i && wready_i && !exp_err) begin
      if (is_st) shadow[base] <= wdata_i[7:0];
      if (op_i == lsu_pkg::SH || op_i == lsu_pkg::SW) shadow[base + IDX_W'(1)] <= wdata_i[15:8];
      if (op_i == lsu_pkg::SW) begin
        shadow[base + IDX_W'(2)] <= wdata_i[23:16];
        shadow[base + IDX_W'(3)] <= wdata_i[31:24];
      end
    end
  end

  // request bookkeeping
  always @(posedge clk) begin
    rst_q <= rst_i;
    if (rst_i) seen_rst_q <= 1'b1;
    if (rst_i || done) begin
      pend_q <= 1'b0;
    end else if (req_i) begin
      pend_q <= 1'b1;
    end
  end

  a_load_data: assert property (@(posedge clk) disable iff (rst_i) rvalid_i |-> rdata_i == exp_rdata)
    else begin
      fail_cnt++;
      $error("MISMATCH %s rdata expected %h actual %h", test_name, $sampled(exp_rdata),
             $sampled(rdata_i));
    end

  a_err: assert property (@(posedge clk) disable iff (rst_i) done |-> err_i == exp_err)
    else begin
      fail_cnt++;
      $error("MISMATCH %s err expected %b actual %b", test_name, $sampled(exp_err),
             $sampled(err_i));
    end

  a_kind: assert property (@(posedge clk) disable iff (rst_i)
      done |-> {rvalid_i, wready_i} == {is_ld, is_st})
    else begin
      fail_cnt++;
      $error("MISMATCH %s pulse kind expected %b actual %b", test_name,
             $sampled({is_ld, is_st}), $sampled({rvalid_i, wready_i}));
    end

  a_pending: assert property (@(posedge clk) disable iff (rst_i) done |-> pend_q)
    else begin
      fail_cnt++;
      $error("%s: completion pulse seen with no request pending", test_name);
    end

  a_reset_quiet: assert property (@(posedge clk)
      (seen_rst_q && (rst_i || rst_q)) |-> {rvalid_i, wready_i, err_i} == 3'b000)
    else begin
      fail_cnt++;
      $error("MISMATCH %s outputs in reset expected 000 actual %b", test_name,
             $sampled({rvalid_i, wready_i, err_i}));
    end

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

//--- logic/lsu_subsys.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_subsys (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  lsu_pkg::mem_op_e         op_i,
  input  logic [`LSU_ADDR_W-1:0]   addr_i,
  input  logic [`LSU_DATA_W-1:0]   wdata_i,
  output logic [`LSU_DATA_W-1:0]   rdata_o,
  output logic                     rvalid_o,
  output logic                     wready_o,
  output logic                     err_o
);

  localparam int N      = `LSU_N_BANKS;
  localparam int SEL_W  = $clog2(`LSU_N_BANKS);
  localparam int WORD_W = $clog2(`LSU_BANK_WORDS);
  localparam int STRB_W = `LSU_DATA_W / 8;

  // lsu side bus
  logic [`LSU_ADDR_W-1:0] ar_addr, aw_addr;
  logic                   ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic [`LSU_DATA_W-1:0] r_data, w_data;
  logic [STRB_W-1:0]      w_strb;
  lsu_pkg::bus_resp_e     r_resp, b_resp;
  logic                   r_valid, r_ready, b_valid, b_ready;
  logic                   ar_fire, aw_fire;

  // bank side
  logic [N-1:0]                  bank_ar_valid, bank_aw_valid, bank_w_valid;
  logic [N-1:0]                  bank_ar_ready, bank_aw_ready, bank_w_ready;
  logic [N-1:0][`LSU_DATA_W-1:0] bank_r_data;
  logic [N-1:0]                  bank_r_valid, bank_b_valid, bank_r_ready, bank_b_ready;
  logic [WORD_W-1:0]             word_addr;
  logic [SEL_W-1:0]              sel;
  logic                          dec_err;

  assign ar_fire = ar_valid & ar_ready;
  assign aw_fire = aw_valid & aw_ready;

  lsu_core lsu_core_i (
    .clk, .rst_i, .req_i, .op_i, .addr_i, .wdata_i,
    .rdata_o, .rvalid_o, .wready_o, .err_o,
    .ar_addr_o(ar_addr), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
    .r_data_i(r_data), .r_resp_i(r_resp), .r_valid_i(r_valid), .r_ready_o(r_ready),
    .aw_addr_o(aw_addr), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
    .w_data_o(w_data), .w_strb_o(w_strb), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .b_resp_i(b_resp), .b_valid_i(b_valid), .b_ready_o(b_ready)
  );

  bank_router bank_router_i (
    .clk, .rst_i,
    .ar_addr_i(ar_addr), .ar_valid_i(ar_valid),
    .aw_addr_i(aw_addr), .aw_valid_i(aw_valid), .w_valid_i(w_valid),
    .bank_ar_ready_i(bank_ar_ready), .bank_aw_ready_i(bank_aw_ready),
    .bank_w_ready_i(bank_w_ready),
    .ar_ready_o(ar_ready), .aw_ready_o(aw_ready), .w_ready_o(w_ready),
    .bank_ar_valid_o(bank_ar_valid), .bank_aw_valid_o(bank_aw_valid),
    .bank_w_valid_o(bank_w_valid),
    .word_addr_o(word_addr), .sel_o(sel), .dec_err_o(dec_err)
  );

  for (genvar g = 0; g < N; g++) begin : g_bank
    mem_bank #(.BANK_ID(g)) mem_bank_i (
      .clk, .rst_i,
      .word_addr_i(word_addr),
      .ar_valid_i(bank_ar_valid[g]), .aw_valid_i(bank_aw_valid[g]),
      .w_valid_i(bank_w_valid[g]), .w_data_i(w_data), .w_strb_i(w_strb),
      .r_ready_i(bank_r_ready[g]), .b_ready_i(bank_b_ready[g]),
      .ar_ready_o(bank_ar_ready[g]), .aw_ready_o(bank_aw_ready[g]),
      .w_ready_o(bank_w_ready[g]),
      .r_data_o(bank_r_data[g]), .r_valid_o(bank_r_valid[g]), .b_valid_o(bank_b_valid[g])
    );
  end

  resp_merge resp_merge_i (
    .clk, .rst_i,
    .sel_i(sel), .dec_err_i(dec_err), .r_ready_i(r_ready), .b_ready_i(b_ready),
    .bank_r_data_i(bank_r_data), .bank_r_valid_i(bank_r_valid),
    .bank_b_valid_i(bank_b_valid), .ar_fire_i(ar_fire), .aw_fire_i(aw_fire),
    .r_data_o(r_data), .r_resp_o(r_resp), .r_valid_o(r_valid),
    .b_resp_o(b_resp), .b_valid_o(b_valid),
    .bank_r_ready_o(bank_r_ready), .bank_b_ready_o(bank_b_ready)
  );

endmodule

//--- logic/resp_merge.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module resp_merge #(
  localparam int SEL_W = $clog2(`LSU_N_BANKS)
) (
  input  logic                                         clk,
  input  logic                                         rst_i,
  input  logic [SEL_W-1:0]                             sel_i,
  input  logic                                         dec_err_i,
  input  logic                                         r_ready_i,
  input  logic                                         b_ready_i,
  input  logic [`LSU_N_BANKS-1:0][`LSU_DATA_W-1:0]     bank_r_data_i,
  input  logic [`LSU_N_BANKS-1:0]                      bank_r_valid_i,
  input  logic [`LSU_N_BANKS-1:0]                      bank_b_valid_i,
  input  logic                                         ar_fire_i,
  input  logic                                         aw_fire_i,
  output logic [`LSU_DATA_W-1:0]                       r_data_o,
  output lsu_pkg::bus_resp_e                           r_resp_o,
  output logic                                         r_valid_o,
  output lsu_pkg::bus_resp_e                           b_resp_o,
  output logic                                         b_valid_o,
  output logic [`LSU_N_BANKS-1:0]                      bank_r_ready_o,
  output logic [`LSU_N_BANKS-1:0]                      bank_b_ready_o
);

  logic r_pend_q;
  logic b_pend_q;

  // outstanding accept, used as the local decerr response
  always_ff @(posedge clk) begin
    if (rst_i) begin
      r_pend_q <= 1'b0;
      b_pend_q <= 1'b0;
    end else begin
      if (ar_fire_i) begin
        r_pend_q <= 1'b1;
      end else if (r_valid_o && r_ready_i) begin
        r_pend_q <= 1'b0;
      end
      if (aw_fire_i) begin
        b_pend_q <= 1'b1;
      end else if (b_valid_o && b_ready_i) begin
        b_pend_q <= 1'b0;
      end
    end
  end

  assign r_valid_o = dec_err_i ? r_pend_q : bank_r_valid_i[sel_i];
  assign r_data_o  = dec_err_i ? '0 : bank_r_data_i[sel_i];
  assign r_resp_o  = dec_err_i ? lsu_pkg::DECERR : lsu_pkg::OKAY;
  assign b_valid_o = dec_err_i ? b_pend_q : bank_b_valid_i[sel_i];
  assign b_resp_o  = dec_err_i ? lsu_pkg::DECERR : lsu_pkg::OKAY;

  always_comb begin
    bank_r_ready_o = '0;
    bank_b_ready_o = '0;
    bank_r_ready_o[sel_i] = r_ready_i & ~dec_err_i;
    bank_b_ready_o[sel_i] = b_ready_i & ~dec_err_i;
  end

endmodule

//--- logic/mem_bank.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module mem_bank #(
  parameter int  BANK_ID = 0,
  localparam int WORD_W  = $clog2(`LSU_BANK_WORDS),
  localparam int STRB_W  = `LSU_DATA_W / 8
) (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic [WORD_W-1:0]         word_addr_i,
  input  logic                      ar_valid_i,
  input  logic                      aw_valid_i,
  input  logic                      w_valid_i,
  input  logic [`LSU_DATA_W-1:0]    w_data_i,
  input  logic [STRB_W-1:0]         w_strb_i,
  input  logic                      r_ready_i,
  input  logic                      b_ready_i,
  output logic                      ar_ready_o,
  output logic                      aw_ready_o,
  output logic                      w_ready_o,
  output logic [`LSU_DATA_W-1:0]    r_data_o,
  output logic                      r_valid_o,
  output logic                      b_valid_o
);

  // bit 0 always set, so the seed is never zero
  localparam logic [19:0] SEED = 20'h5a5a1 ^ 20'(BANK_ID << 4);

  logic [`LSU_DATA_W-1:0] mem [`LSU_BANK_WORDS];
  logic [19:0]            lfsr_q;
  logic                   stall_ok;
  logic                   ar_fire;
  logic                   wr_fire;

  // x^20 + x^17 + 1
  always_ff @(posedge clk) begin
    if (rst_i) begin
      lfsr_q <= SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  assign stall_ok = (`LSU_STALL_EN != 0) ? lfsr_q[19] : 1'b1;

  // aw and w are taken together, so each ready waits on the other valid
  assign ar_ready_o = stall_ok & ~r_valid_o;
  assign aw_ready_o = stall_ok & ~b_valid_o & w_valid_i;
  assign w_ready_o  = stall_ok & ~b_valid_o & aw_valid_i;

  assign ar_fire = ar_valid_i & ar_ready_o;
  assign wr_fire = aw_valid_i & aw_ready_o;

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (w_strb_i[b]) mem[word_addr_i][b*8 +: 8] <= w_data_i[b*8 +: 8];
      end
    end
    if (ar_fire) r_data_o <= mem[word_addr_i];
  end

  // responses hold until taken
  always_ff @(posedge clk) begin
    if (rst_i) begin
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
    end else begin
      if (ar_fire) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
      if (wr_fire) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
    end
  end

endmodule

//--- logic/bank_router.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module bank_router #(
  localparam int SEL_W  = $clog2(`LSU_N_BANKS),
  localparam int WORD_W = $clog2(`LSU_BANK_WORDS)
) (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic [`LSU_ADDR_W-1:0]    ar_addr_i,
  input  logic                      ar_valid_i,
  input  logic [`LSU_ADDR_W-1:0]    aw_addr_i,
  input  logic                      aw_valid_i,
  input  logic                      w_valid_i,
  input  logic [`LSU_N_BANKS-1:0]   bank_ar_ready_i,
  input  logic [`LSU_N_BANKS-1:0]   bank_aw_ready_i,
  input  logic [`LSU_N_BANKS-1:0]   bank_w_ready_i,
  output logic                      ar_ready_o,
  output logic                      aw_ready_o,
  output logic                      w_ready_o,
  output logic [`LSU_N_BANKS-1:0]   bank_ar_valid_o,
  output logic [`LSU_N_BANKS-1:0]   bank_aw_valid_o,
  output logic [`LSU_N_BANKS-1:0]   bank_w_valid_o,
  output logic [WORD_W-1:0]         word_addr_o,
  output logic [SEL_W-1:0]          sel_o,
  output logic                      dec_err_o
);

  localparam int unsigned LIMIT = `LSU_N_BANKS * `LSU_BANK_WORDS * 4;

  logic [SEL_W-1:0] ar_idx;
  logic [SEL_W-1:0] aw_idx;
  logic             ar_bad;
  logic             aw_bad;

  // bank index sits just above the byte offset
  assign ar_idx = ar_addr_i[2 +: SEL_W];
  assign aw_idx = aw_addr_i[2 +: SEL_W];
  assign ar_bad = ar_addr_i >= LIMIT;
  assign aw_bad = aw_addr_i >= LIMIT;

  always_comb begin
    bank_ar_valid_o = '0;
    bank_aw_valid_o = '0;
    bank_w_valid_o  = '0;
    bank_ar_valid_o[ar_idx] = ar_valid_i & ~ar_bad;
    bank_aw_valid_o[aw_idx] = aw_valid_i & ~aw_bad;
    bank_w_valid_o[aw_idx]  = w_valid_i & ~aw_bad;
  end

  // out of range requests are taken here at once
  assign ar_ready_o = ar_bad | bank_ar_ready_i[ar_idx];
  assign aw_ready_o = aw_bad | bank_aw_ready_i[aw_idx];
  assign w_ready_o  = aw_bad | bank_w_ready_i[aw_idx];

  assign word_addr_o = ar_valid_i ? ar_addr_i[2 + SEL_W +: WORD_W]
                                  : aw_addr_i[2 + SEL_W +: WORD_W];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sel_o     <= '0;
      dec_err_o <= 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      sel_o     <= ar_idx;
      dec_err_o <= ar_bad;
    end else if (aw_valid_i && aw_ready_o) begin
      sel_o     <= aw_idx;
      dec_err_o <= aw_bad;
    end
  end

endmodule

//--- lsu/lsu_core.sv
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_core (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       req_i,
  input  lsu_pkg::mem_op_e           op_i,
  input  logic [`LSU_ADDR_W-1:0]     addr_i,
  input  logic [`LSU_DATA_W-1:0]     wdata_i,
  output logic [`LSU_DATA_W-1:0]     rdata_o,
  output logic                       rvalid_o,
  output logic                       wready_o,
  output logic                       err_o,
  // read address / data
  output logic [`LSU_ADDR_W-1:0]     ar_addr_o,
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  input  logic [`LSU_DATA_W-1:0]     r_data_i,
  input  lsu_pkg::bus_resp_e         r_resp_i,
  input  logic                       r_valid_i,
  output logic                       r_ready_o,
  // write address / data / response
  output logic [`LSU_ADDR_W-1:0]     aw_addr_o,
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,
  output logic [`LSU_DATA_W-1:0]     w_data_o,
  output logic [`LSU_DATA_W/8-1:0]   w_strb_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,
  input  lsu_pkg::bus_resp_e         b_resp_i,
  input  logic                       b_valid_i,
  output logic                       b_ready_o
);

  localparam int STRB_W = `LSU_DATA_W / 8;

  lsu_pkg::lsu_state_e       state_q;
  lsu_pkg::mem_op_e          op_q;
  logic [`LSU_ADDR_W-1:0]    addr_q;
  logic [`LSU_DATA_W-1:0]    wdata_q;
  logic [`LSU_DATA_W-1:0]    rdata_q;
  logic                      err_q;
  logic                      aw_done_q;
  logic                      w_done_q;
  logic                      is_load;
  logic                      is_store;
  logic [`LSU_DATA_W-1:0]    r_shift;
  logic [`LSU_DATA_W-1:0]    load_ext;
  logic [STRB_W-1:0]         strb_base;

  assign is_load  = op_q inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH, lsu_pkg::LHU,
                                 lsu_pkg::LW};
  assign is_store = op_q inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= lsu_pkg::IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      case (state_q)
        lsu_pkg::IDLE: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          err_q     <= 1'b0;
          if (req_i && op_i != lsu_pkg::NONE) state_q <= lsu_pkg::ADDR;
        end
        lsu_pkg::ADDR: begin
          if (is_load) begin
            if (ar_ready_i) state_q <= lsu_pkg::DATA;
          end else begin
            // aw and w may be taken in different cycles
            aw_done_q <= aw_done_q | aw_ready_i;
            w_done_q  <= w_done_q | w_ready_i;
            if ((aw_done_q | aw_ready_i) && (w_done_q | w_ready_i)) begin
              state_q <= lsu_pkg::DATA;
            end
          end
        end
        lsu_pkg::DATA: begin
          if (is_load && r_valid_i) begin
            err_q   <= (r_resp_i == lsu_pkg::DECERR);
            state_q <= lsu_pkg::DONE;
          end else if (is_store && b_valid_i) begin
            err_q   <= (b_resp_i == lsu_pkg::DECERR);
            state_q <= lsu_pkg::DONE;
          end
        end
        default: state_q <= lsu_pkg::IDLE;
      endcase
    end
  end

  // request payload and load result
  always_ff @(posedge clk) begin
    if (state_q == lsu_pkg::IDLE && req_i) begin
      op_q    <= op_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (state_q == lsu_pkg::DATA && is_load && r_valid_i) rdata_q <= load_ext;
  end

  // load alignment and extension
  always_comb begin
    r_shift = r_data_i >> {addr_q[1:0], 3'b000};
    case (op_q)
      lsu_pkg::LB:  load_ext = {{(`LSU_DATA_W-8){r_shift[7]}}, r_shift[7:0]};
      lsu_pkg::LBU: load_ext = {{(`LSU_DATA_W-8){1'b0}}, r_shift[7:0]};
      lsu_pkg::LH:  load_ext = {{(`LSU_DATA_W-16){r_shift[15]}}, r_shift[15:0]};
      lsu_pkg::LHU: load_ext = {{(`LSU_DATA_W-16){1'b0}}, r_shift[15:0]};
      default:      load_ext = r_shift;
    endcase
  end

  // strobe widths before shifting into lane
  always_comb begin
    case (op_q)
      lsu_pkg::SB: strb_base = STRB_W'(4'b0001);
      lsu_pkg::SH: strb_base = STRB_W'(4'b0011);
      default:     strb_base = '1;
    endcase
  end

  assign ar_addr_o  = addr_q;
  assign ar_valid_o = (state_q == lsu_pkg::ADDR) && is_load;
  assign r_ready_o  = (state_q == lsu_pkg::DATA) && is_load;

  assign aw_addr_o  = addr_q;
  assign aw_valid_o = (state_q == lsu_pkg::ADDR) && is_store && !aw_done_q;
  assign w_data_o   = wdata_q << {addr_q[1:0], 3'b000};
  assign w_strb_o   = strb_base << addr_q[1:0];
  assign w_valid_o  = (state_q == lsu_pkg::ADDR) && is_store && !w_done_q;
  assign b_ready_o  = (state_q == lsu_pkg::DATA) && is_store;

  assign rdata_o  = rdata_q;
  assign rvalid_o = (state_q == lsu_pkg::DONE) && is_load;
  assign wready_o = (state_q == lsu_pkg::DONE) && is_store;
  assign err_o    = (state_q == lsu_pkg::DONE) && err_q;

endmodule

//--- common/lsu_pkg.sv
package lsu_pkg;

  // memory operations from the execute stage
  typedef enum logic [3:0] {
    NONE = 4'd0,
    LB   = 4'd1,
    LBU  = 4'd2,
    LH   = 4'd3,
    LHU  = 4'd4,
    LW   = 4'd5,
    SB   = 4'd6,
    SH   = 4'd7,
    SW   = 4'd8
  } mem_op_e;

  // only the two response codes the banks can give
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } bus_resp_e;

  // lsu_core request sequencing
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ADDR = 2'd1,
    DATA = 2'd2,
    DONE = 2'd3
  } lsu_state_e;

endpackage

//--- common/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// bank layout, word interleaved, bank count a power of two
`define LSU_N_BANKS 4
`define LSU_BANK_WORDS 64

// 1 lets the bank lfsr stall the ready signals
`define LSU_STALL_EN 1

`endif
